// ==== sources.f ====
verilog/cpu_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/ex_mem_if.sv
verilog/mem_wb_if.sv
verilog/alu_unit.sv
verilog/ex_mem_pipe_reg.sv
verilog/memory_stage.sv
verilog/mem_wb_pipe_reg.sv
verilog/cpu_backend.sv
verif/cpu_backend_assert.sv
verif/cpu_backend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cpu_backend testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall \
  -f sources.f \
  --top-module cpu_backend_tb \
  -o Vcpu_backend_tb

out=$(./obj_dir/Vcpu_backend_tb)
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
  exit 0
else
  exit 1
fi

// ==== verif/cpu_backend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_backend_tb;

  logic                   clk;
  logic                   rst_n;
  logic                   stall;
  logic                   flush;
  cpu_isa_pkg::word_t     id_ex_pc_next;
  cpu_isa_pkg::opcode_t   id_ex_opcode;
  cpu_isa_pkg::word_t     operand_a;
  cpu_isa_pkg::word_t     operand_b;
  cpu_isa_pkg::reg_addr_t id_ex_src_reg2;
  pipe_pkg::mem_ctrl_t    id_ex_mem_signals;
  pipe_pkg::wb_ctrl_t     id_ex_wb_signals;
  logic                   wb_reg_write;
  cpu_isa_pkg::reg_addr_t wb_reg_rd;
  cpu_isa_pkg::word_t     wb_data;
  logic                   halt;
  cpu_isa_pkg::flags_t    flags;

  integer               seed = 32'h5f0a_07a2;
  integer               err_count = 0;
  integer               check_count = 0;
  cpu_isa_pkg::flags_t  exp_flags;     // Model copy of the flag register
  cpu_isa_pkg::opcode_t op_list [10] = '{4'd0, 4'd1, 4'd2, 4'd4, 4'd5,
                                         4'd6, 4'd8, 4'd9, 4'd10, 4'd11};

  cpu_backend #(.MEM_ADDR_WIDTH(8)) dut_i (.*);

  always #2 clk = ~clk; // 4 ns period

  // Hard limit on the whole run
  initial begin
    #200000;
    $display("Timeout: the test sequence did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  ////////////////////
  // Reference model
  ////////////////////
  function automatic logic overflowed(input logic signed [16:0] v);
    return (v > 17'sd32767) || (v < -17'sd32768);
  endfunction

  function automatic cpu_isa_pkg::word_t model_alu(input cpu_isa_pkg::opcode_t op,
                                                   input cpu_isa_pkg::word_t a,
                                                   input cpu_isa_pkg::word_t b);
    logic signed [16:0] wide;
    logic [3:0]         sh;
    sh = b[3:0];
    wide = (op == 4'd1) ? $signed({a[15], a}) - $signed({b[15], b})
                        : $signed({a[15], a}) + $signed({b[15], b});
    case (op)
      4'd0, 4'd1: begin
        if (wide > 17'sd32767) return 16'h7FFF; // Clamp at the positive limit
        if (wide < -17'sd32768) return 16'h8000;
        return wide[15:0];
      end
      4'd2:       return a ^ b;
      4'd4:       return a << sh;
      4'd5:       return $signed(a) >>> sh;
      4'd6:       return (a >> sh) | (a << (16 - sh)); // Zero shift leaves a as it is
      4'd8, 4'd9: return a + b;
      4'd10:      return {a[15:8], b[7:0]};
      4'd11:      return {b[7:0], a[7:0]};
      default:    return 16'h0000;
    endcase
  endfunction

  // Z on ALU and shift ops, V and N on ADD and SUB only
  function automatic cpu_isa_pkg::flags_t model_flags(input cpu_isa_pkg::opcode_t op,
                                                      input cpu_isa_pkg::word_t a,
                                                      input cpu_isa_pkg::word_t b,
                                                      input cpu_isa_pkg::flags_t old);
    cpu_isa_pkg::flags_t f;
    cpu_isa_pkg::word_t  res;
    logic signed [16:0]  wide;
    f = old;
    res = model_alu(op, a, b);
    wide = (op == 4'd1) ? $signed({a[15], a}) - $signed({b[15], b})
                        : $signed({a[15], a}) + $signed({b[15], b});
    if (op <= 4'd2 || (op >= 4'd4 && op <= 4'd6)) f[2] = (res == 16'h0000);
    if (op <= 4'd1) begin
      f[1] = overflowed(wide);
      f[0] = res[15];
    end
    return f;
  endfunction

  ////////////////////
  // Checks and drivers
  ////////////////////
  task automatic check(input string name, input logic [15:0] actual,
                       input logic [15:0] expected);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("ERROR at %0t: %s actual %h expected %h", $time, name, actual, expected);
    end
  endtask

  // One entry presented on a falling edge, sampled at the next rising edge
  task automatic drive(input cpu_isa_pkg::opcode_t op, input cpu_isa_pkg::word_t a,
                       input cpu_isa_pkg::word_t b, input cpu_isa_pkg::reg_addr_t s2,
                       input pipe_pkg::mem_ctrl_t m, input pipe_pkg::wb_ctrl_t w,
                       input cpu_isa_pkg::word_t pcn);
    @(negedge clk);
    id_ex_opcode      = op;
    operand_a         = a;
    operand_b         = b;
    id_ex_src_reg2    = s2;
    id_ex_mem_signals = m;
    id_ex_wb_signals  = w;
    id_ex_pc_next     = pcn;
  endtask

  task automatic idle();
    drive(4'd10, 16'h0, 16'h0, 4'h0, '0, '0, 16'h0); // LLB bubble, touches no flag
  endtask

  // Entry, then the flags one cycle later and the writeback port two cycles later
  task automatic send_entry(input cpu_isa_pkg::opcode_t op, input cpu_isa_pkg::word_t a,
                            input cpu_isa_pkg::word_t b, input cpu_isa_pkg::reg_addr_t s2,
                            input pipe_pkg::mem_ctrl_t m, input pipe_pkg::wb_ctrl_t w,
                            input cpu_isa_pkg::word_t pcn, input cpu_isa_pkg::word_t exp_data);
    drive(op, a, b, s2, m, w, pcn);
    exp_flags = model_flags(op, a, b, exp_flags);
    idle();
    check("flags", 16'(flags), 16'(exp_flags));
    idle();
    check("wb_reg_write", 16'(wb_reg_write), 16'(w[3]));
    if (w[3]) begin
      check("wb_reg_rd", 16'(wb_reg_rd), 16'(w[7:4]));
      check("wb_data", wb_data, exp_data);
    end
  endtask

  task automatic store(input logic [7:0] addr, input cpu_isa_pkg::word_t data);
    send_entry(4'd9, 16'(addr), 16'h0, 4'h0, {data, 2'b11}, '0, 16'h0, 16'h0);
  endtask

  task automatic load_check(input logic [7:0] addr, input cpu_isa_pkg::reg_addr_t rd,
                            input cpu_isa_pkg::word_t exp_data);
    send_entry(4'd8, 16'(addr), 16'h0, 4'h0, {16'h0, 2'b10}, {rd, 4'b1100}, 16'h0,
               exp_data);
  endtask

  ////////////////////
  // Directed tests
  ////////////////////
  task automatic test_reset_values();
    check("wb_reg_write after reset", 16'(wb_reg_write), 16'h0);
    check("halt after reset", 16'(halt), 16'h0);
    check("flags after reset", 16'(flags), 16'h0);
  endtask

  task automatic test_alu_ops();
    cpu_isa_pkg::word_t     a;
    cpu_isa_pkg::word_t     b;
    cpu_isa_pkg::reg_addr_t rd;
    foreach (op_list[i]) begin
      repeat (6) begin
        a  = $random(seed);
        b  = $random(seed);
        rd = $random(seed);
        send_entry(op_list[i], a, b, 4'h0, '0, {rd, 4'b1000}, 16'h0,
                   model_alu(op_list[i], a, b));
      end
    end
    send_entry(4'd0, 16'h0001, 16'hFFFF, 4'h0, '0, 8'h78, 16'h0, 16'h0000); // Z set
    // Saturation at both limits, for ADD and SUB
    send_entry(4'd0, 16'h7000, 16'h7000, 4'h0, '0, 8'h38, 16'h0, 16'h7FFF);
    send_entry(4'd0, 16'h8000, 16'h8000, 4'h0, '0, 8'h38, 16'h0, 16'h8000);
    send_entry(4'd1, 16'h8000, 16'h0001, 4'h0, '0, 8'h58, 16'h0, 16'h8000);
    send_entry(4'd1, 16'h7FFF, 16'hFFFF, 4'h0, '0, 8'h68, 16'h0, 16'h7FFF);
    send_entry(4'd2, 16'h1234, 16'h1234, 4'h0, '0, 8'h88, 16'h0, 16'h0000); // V, N kept
  endtask

  task automatic test_store_load();
    store(8'h21, 16'hBEEF);
    load_check(8'h21, 4'h3, 16'hBEEF);
    store(8'h40, 16'hC0DE);
    // Load into r5, then a store of r5 right behind it with stale bundle data
    drive(4'd8, 16'h0040, 16'h0, 4'h0, {16'h0, 2'b10}, {4'h5, 4'b1100}, 16'h0);
    drive(4'd9, 16'h0041, 16'h0, 4'h5, {16'hDEAD, 2'b11}, '0, 16'h0);
    idle();
    idle();
    load_check(8'h41, 4'h6, 16'hC0DE);
  endtask

  task automatic test_stall_flush();
    cpu_isa_pkg::word_t exp_wb;
    // ADD into r9 ahead of the store, so WB holds a live register write during the stall
    exp_wb    = model_alu(4'd0, 16'h1200, 16'h0034);
    exp_flags = model_flags(4'd0, 16'h1200, 16'h0034, exp_flags);
    drive(4'd0, 16'h1200, 16'h0034, 4'h0, '0, 8'h98, 16'h0);
    drive(4'd9, 16'h0060, 16'h0, 4'h0, {16'hA5A5, 2'b11}, '0, 16'h0);
    // Saturating ADD held in EX would set V and N if the stall leaked through
    drive(4'd0, 16'h8000, 16'h8000, 4'h0, '0, '0, 16'h0);
    stall = 1'b1; // Store now sits in MEM and must wait
    repeat (5) begin
      @(negedge clk);
      check("wb_data during stall", wb_data, exp_wb);
      check("wb_reg_write during stall", 16'(wb_reg_write), 16'h1);
      check("flags during stall", 16'(flags), 16'(exp_flags));
      check("data_mem[60] during stall", dut_i.mem_stage_i.data_mem[8'h60], 16'h0000);
    end
    stall = 1'b0;
    exp_flags = model_flags(4'd0, 16'h8000, 16'h8000, exp_flags); // Held ADD goes ahead
    idle();
    idle();
    load_check(8'h60, 4'h7, 16'hA5A5);
    // Flushed store with RegWrite set
    drive(4'd9, 16'h0070, 16'h0, 4'h0, {16'h5A5A, 2'b11}, 8'h98, 16'h0);
    flush = 1'b1;
    idle();
    flush = 1'b0;
    repeat (4) begin
      idle();
      check("wb_reg_write after flush", 16'(wb_reg_write), 16'h0);
    end
    load_check(8'h70, 4'h8, 16'h0000);
  endtask

  task automatic test_pcs_halt();
    integer cycles;
    send_entry(4'd0, 16'h0003, 16'h0004, 4'h0, '0, 8'hA9, 16'h1F42, 16'h1F42);
    drive(4'd10, 16'h0, 16'h0, 4'h0, '0, 8'h02, 16'h0);
    cycles = 0;
    while (!halt && cycles < 20) begin // Third falling edge, counting the one that drove HLT
      idle();
      cycles++;
    end
    if (!halt) begin
      err_count++;
      $display("Timeout: halt never rose after a HLT entry");
    end else begin
      check("halt latency in falling edges", 16'(cycles + 1), 16'd3);
    end
  endtask

  initial begin
    clk               = 1'b0;
    rst_n             = 1'b0;
    stall             = 1'b0;
    flush             = 1'b0;
    id_ex_pc_next     = '0;
    id_ex_opcode      = 4'd10;
    operand_a         = '0;
    operand_b         = '0;
    id_ex_src_reg2    = '0;
    id_ex_mem_signals = '0;
    id_ex_wb_signals  = '0;
    exp_flags         = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    test_reset_values();
    test_alu_ops();
    test_store_load();
    test_stall_flush();
    test_pcs_halt();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count, err_count,
             dut_i.assert_i.fail_count);
    if (err_count == 0 && dut_i.assert_i.fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/cpu_backend_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

// Protocol properties of the back end, bound into every cpu_backend instance
module cpu_backend_assert (
  input wire logic                 clk,
  input wire logic                 rst_n,
  input wire logic                 stall,
  input wire logic                 flush,
  input wire logic                 wb_reg_write,
  input wire cpu_isa_pkg::word_t   wb_data,
  input wire logic                 halt,
  input wire cpu_isa_pkg::flags_t  flags
);

  int fail_count = 0; // Number of property failures so far

  // Control outputs stay quiet while reset is held
  reset_quiet_a: assert property (@(posedge clk)
    !rst_n |-> (!wb_reg_write && !halt && flags == '0))
    else begin
      fail_count++;
      $error("control output active during reset");
    end

  // A stalled edge leaves the writeback port and flags as they were
  stall_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> ($stable(wb_data) && $stable(wb_reg_write) && $stable(flags)))
    else begin
      fail_count++;
      $error("writeback outputs moved during stall");
    end

  // Bubble reaches WB two edges after the flush was sampled
  flush_bubble_a: assert property (@(posedge clk) disable iff (!rst_n)
    (flush && !stall) ##1 !stall |=> !wb_reg_write)
    else begin
      fail_count++;
      $error("flushed entry wrote the register file");
    end

endmodule

bind cpu_backend cpu_backend_assert assert_i (.*);

`default_nettype wire

// ==== verilog/cpu_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

// Back end of the pipeline, EX through WB, fed with decoded ID/EX values
module cpu_backend #(
  parameter int MEM_ADDR_WIDTH = 8 // 256 word data memory by default
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall,             // Global freeze
  input  logic                   flush,             // Bubble the entry leaving EX
  input  cpu_isa_pkg::word_t     id_ex_pc_next,
  input  cpu_isa_pkg::opcode_t   id_ex_opcode,
  input  cpu_isa_pkg::word_t     operand_a,         // Already forwarded
  input  cpu_isa_pkg::word_t     operand_b,
  input  cpu_isa_pkg::reg_addr_t id_ex_src_reg2,
  input  pipe_pkg::mem_ctrl_t    id_ex_mem_signals,
  input  pipe_pkg::wb_ctrl_t     id_ex_wb_signals,
  output logic                   wb_reg_write,      // Register file write port
  output cpu_isa_pkg::reg_addr_t wb_reg_rd,
  output cpu_isa_pkg::word_t     wb_data,
  output logic                   halt,
  output cpu_isa_pkg::flags_t    flags
);

  cpu_isa_pkg::word_t alu_out;

  ex_mem_if ex_mem_bus ();
  mem_wb_if mem_wb_bus ();

  ////////////////////
  // EX
  ////////////////////
  alu_unit alu_i (
    .clk(clk), .rst_n(rst_n), .stall(stall),
    .opcode(id_ex_opcode), .operand_a(operand_a), .operand_b(operand_b),
    .alu_out(alu_out), .flags(flags)
  );

  ex_mem_pipe_reg ex_mem_reg_i (
    .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
    .pc_next(id_ex_pc_next), .alu_out(alu_out), .src_reg2(id_ex_src_reg2),
    .mem_ctrl(id_ex_mem_signals), .wb_ctrl(id_ex_wb_signals),
    .ex_mem(ex_mem_bus)
  );

  ////////////////////
  // MEM and WB
  ////////////////////
  memory_stage #(
    .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
  ) mem_stage_i (
    .clk(clk), .rst_n(rst_n), .stall(stall),
    .ex_mem(ex_mem_bus), .mem_wb(mem_wb_bus), .wb_fwd(mem_wb_bus) // Same bus, other modport
  );

  mem_wb_pipe_reg mem_wb_reg_i (
    .clk(clk), .rst_n(rst_n), .stall(stall),
    .mem_wb(mem_wb_bus), .wb_fwd(mem_wb_bus),
    .wb_reg_write(wb_reg_write), .wb_reg_rd(wb_reg_rd), .wb_data(wb_data), .halt(halt)
  );

endmodule

`default_nettype wire

// ==== verilog/mem_wb_pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

// MEM/WB pipeline register and the writeback value mux
module mem_wb_pipe_reg (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall,
  mem_wb_if.sink                 mem_wb,
  mem_wb_if.fwd_src              wb_fwd,       // Back to the memory stage
  output logic                   wb_reg_write,
  output cpu_isa_pkg::reg_addr_t wb_reg_rd,
  output cpu_isa_pkg::word_t     wb_data,
  output logic                   halt
);

  cpu_isa_pkg::word_t pc_next_q;
  cpu_isa_pkg::word_t alu_out_q;
  cpu_isa_pkg::word_t mem_rdata_q;
  logic               memtoreg_q;
  logic               pcs_q;

  ////////////////////
  // Registers
  ////////////////////
  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_next_q   <= mem_wb.pc_next;
      alu_out_q   <= mem_wb.alu_out;
      mem_rdata_q <= mem_wb.mem_rdata;
      wb_reg_rd   <= mem_wb.wb_ctrl[pipe_pkg::WB_RD_LSB +: $bits(cpu_isa_pkg::reg_addr_t)];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_reg_write <= 1'b0;
      memtoreg_q   <= 1'b0;
      halt         <= 1'b0;
      pcs_q        <= 1'b0;
    end else if (!stall) begin
      wb_reg_write <= mem_wb.wb_ctrl[pipe_pkg::WB_REGWRITE_BIT];
      memtoreg_q   <= mem_wb.wb_ctrl[pipe_pkg::WB_MEMTOREG_BIT];
      halt         <= mem_wb.wb_ctrl[pipe_pkg::WB_HLT_BIT];
      pcs_q        <= mem_wb.wb_ctrl[pipe_pkg::WB_PCS_BIT];
    end
  end

  // PCS beats MemtoReg, which beats the ALU result
  always_comb begin
    if (pcs_q) wb_data = pc_next_q;
    else if (memtoreg_q) wb_data = mem_rdata_q;
    else wb_data = alu_out_q;
  end

  assign wb_fwd.fwd_data    = wb_data;
  assign wb_fwd.fwd_wb_ctrl = {wb_reg_rd, wb_reg_write, memtoreg_q, halt, pcs_q};

endmodule

`default_nettype wire

// ==== verilog/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// MEM stage: private data memory with a store-data bypass from the writeback stage
module memory_stage #(
  parameter int MEM_ADDR_WIDTH = 8 // Word address bits, depth is 2**MEM_ADDR_WIDTH
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     stall, // Blocks the memory write
  ex_mem_if.sink   ex_mem,
  mem_wb_if.source mem_wb,
  mem_wb_if.fwd    wb_fwd
);

  localparam int MEM_DEPTH = 1 << MEM_ADDR_WIDTH;

  cpu_isa_pkg::word_t        data_mem [MEM_DEPTH];
  logic [MEM_ADDR_WIDTH-1:0] mem_addr;    // Low bits of the ALU result
  cpu_isa_pkg::word_t        bundle_wdata;
  cpu_isa_pkg::word_t        store_data;  // After the forwarding mux
  cpu_isa_pkg::reg_addr_t    wb_rd;
  logic                      mem_en;
  logic                      mem_wr;
  logic                      is_store;
  logic                      fwd_hit;
  logic                      mem_we;

  assign mem_addr     = ex_mem.alu_out[MEM_ADDR_WIDTH-1:0];
  assign bundle_wdata = ex_mem.mem_ctrl[pipe_pkg::MEM_WDATA_LSB +: $bits(cpu_isa_pkg::word_t)];
  assign mem_en       = ex_mem.mem_ctrl[pipe_pkg::MEM_EN_BIT];
  assign mem_wr       = ex_mem.mem_ctrl[pipe_pkg::MEM_WR_BIT];
  assign is_store     = mem_en & mem_wr;

  ////////////////////
  // Store forwarding
  ////////////////////
  // A load or ALU op one slot ahead has not reached the register file yet
  assign wb_rd   = wb_fwd.fwd_wb_ctrl[pipe_pkg::WB_RD_LSB +: $bits(cpu_isa_pkg::reg_addr_t)];
  assign fwd_hit = is_store && wb_fwd.fwd_wb_ctrl[pipe_pkg::WB_REGWRITE_BIT] &&
                   (wb_rd == ex_mem.src_reg2);
  assign store_data = fwd_hit ? wb_fwd.fwd_data : bundle_wdata;

  ////////////////////
  // Data memory
  ////////////////////
  assign mem_we = is_store & ~stall; // Stalled store waits in MEM

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < MEM_DEPTH; i++) begin
        data_mem[i] <= '0;
      end
    end else if (mem_we) begin
      data_mem[mem_addr] <= store_data;
    end
  end

  // Asynchronous read, the MEM/WB register captures it at the end of the cycle
  assign mem_wb.mem_rdata = data_mem[mem_addr];

  // Everything else rides through untouched
  assign mem_wb.pc_next = ex_mem.pc_next;
  assign mem_wb.alu_out = ex_mem.alu_out;
  assign mem_wb.wb_ctrl = ex_mem.wb_ctrl;

endmodule

`default_nettype wire

// ==== verilog/ex_mem_pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

// EX/MEM pipeline register, one field at a time, with hold on stall and bubble on flush
module ex_mem_pipe_reg (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall,    // Holds every field
  input  logic                   flush,    // Kills the incoming entry
  input  cpu_isa_pkg::word_t     pc_next,
  input  cpu_isa_pkg::word_t     alu_out,
  input  cpu_isa_pkg::reg_addr_t src_reg2,
  input  pipe_pkg::mem_ctrl_t    mem_ctrl,
  input  pipe_pkg::wb_ctrl_t     wb_ctrl,
  ex_mem_if.source               ex_mem
);

  cpu_isa_pkg::word_t     pc_next_q;
  cpu_isa_pkg::word_t     alu_out_q;
  cpu_isa_pkg::reg_addr_t src_reg2_q;
  cpu_isa_pkg::word_t     mem_wdata_q; // Store data from the memory bundle
  cpu_isa_pkg::reg_addr_t reg_rd_q;    // Destination from the writeback bundle
  logic                   mem_en_q;
  logic                   mem_wr_q;
  logic                   reg_write_q;
  logic                   memtoreg_q;
  logic                   hlt_q;
  logic                   pcs_q;

  ////////////////////
  // Payload fields
  ////////////////////
  always_ff @(posedge clk) begin
    if (!stall) begin // Kept on flush, a bubble only needs its enables cleared
      pc_next_q   <= pc_next;
      alu_out_q   <= alu_out;
      src_reg2_q  <= src_reg2;
      mem_wdata_q <= mem_ctrl[pipe_pkg::MEM_WDATA_LSB +: $bits(cpu_isa_pkg::word_t)];
      reg_rd_q    <= wb_ctrl[pipe_pkg::WB_RD_LSB +: $bits(cpu_isa_pkg::reg_addr_t)];
    end
  end

  ////////////////////
  // Control fields
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_en_q    <= 1'b0;
      mem_wr_q    <= 1'b0;
      reg_write_q <= 1'b0;
      memtoreg_q  <= 1'b0;
      hlt_q       <= 1'b0;
      pcs_q       <= 1'b0;
    end else if (!stall) begin // Stall wins over flush
      mem_en_q    <= mem_ctrl[pipe_pkg::MEM_EN_BIT] & ~flush;
      mem_wr_q    <= mem_ctrl[pipe_pkg::MEM_WR_BIT] & ~flush;
      reg_write_q <= wb_ctrl[pipe_pkg::WB_REGWRITE_BIT] & ~flush;
      memtoreg_q  <= wb_ctrl[pipe_pkg::WB_MEMTOREG_BIT]; // Harmless without RegWrite
      hlt_q       <= wb_ctrl[pipe_pkg::WB_HLT_BIT] & ~flush;
      pcs_q       <= wb_ctrl[pipe_pkg::WB_PCS_BIT] & ~flush;
    end
  end

  // Reassemble the bundles in the same layout they arrived in
  assign ex_mem.pc_next  = pc_next_q;
  assign ex_mem.alu_out  = alu_out_q;
  assign ex_mem.src_reg2 = src_reg2_q;
  assign ex_mem.mem_ctrl = {mem_wdata_q, mem_en_q, mem_wr_q};
  assign ex_mem.wb_ctrl  = {reg_rd_q, reg_write_q, memtoreg_q, hlt_q, pcs_q};

endmodule

`default_nettype wire

// ==== verilog/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

// Execute stage ALU, combinational result with a registered Z/V/N flag set
module alu_unit (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall,     // Freezes the flag register
  input  cpu_isa_pkg::opcode_t   opcode,
  input  cpu_isa_pkg::word_t     operand_a,
  input  cpu_isa_pkg::word_t     operand_b,
  output cpu_isa_pkg::word_t     alu_out,
  output cpu_isa_pkg::flags_t    flags
);

  cpu_isa_pkg::word_t add_raw;   // Wrapping sum, also used for LW/SW addresses
  cpu_isa_pkg::word_t sub_raw;   // Wrapping difference
  logic               add_ovf;
  logic               sub_ovf;
  logic               arith_ovf; // Overflow of whichever of ADD or SUB is active
  logic [3:0]         shamt;
  logic [31:0]        rot_wide;  // Operand doubled so a right shift gives the rotation
  logic               is_arith;
  logic               sets_z;

  ////////////////////
  // Datapath
  ////////////////////
  assign add_raw = operand_a + operand_b;
  assign sub_raw = operand_a - operand_b;

  // Same signs in, different sign out
  assign add_ovf = (operand_a[15] == operand_b[15]) && (add_raw[15] != operand_a[15]);
  // Different signs in, result sign differs from the minuend
  assign sub_ovf = (operand_a[15] != operand_b[15]) && (sub_raw[15] != operand_a[15]);

  assign arith_ovf = (opcode == cpu_isa_pkg::OP_SUB) ? sub_ovf : add_ovf;
  assign shamt     = operand_b[3:0];
  assign rot_wide  = {operand_a, operand_a} >> shamt;

  always_comb begin
    case (opcode)
      cpu_isa_pkg::OP_ADD,
      cpu_isa_pkg::OP_SUB: begin
        if (arith_ovf) begin
          // Clamp toward the sign of operand_a, which is the sign that overflowed
          alu_out = operand_a[15] ? 16'h8000 : 16'h7FFF;
        end else begin
          alu_out = (opcode == cpu_isa_pkg::OP_SUB) ? sub_raw : add_raw;
        end
      end
      cpu_isa_pkg::OP_XOR: alu_out = operand_a ^ operand_b;
      cpu_isa_pkg::OP_SLL: alu_out = operand_a << shamt;
      cpu_isa_pkg::OP_SRA: alu_out = $signed(operand_a) >>> shamt; // Sign fill
      cpu_isa_pkg::OP_ROR: alu_out = rot_wide[15:0];
      cpu_isa_pkg::OP_LW,
      cpu_isa_pkg::OP_SW:  alu_out = add_raw;                      // No saturation on addresses
      cpu_isa_pkg::OP_LLB: alu_out = {operand_a[15:8], operand_b[7:0]};
      cpu_isa_pkg::OP_LHB: alu_out = {operand_b[7:0], operand_a[7:0]};
      default:             alu_out = '0;                           // Unused opcodes
    endcase
  end

  ////////////////////
  // Flag register
  ////////////////////
  assign is_arith = (opcode == cpu_isa_pkg::OP_ADD) || (opcode == cpu_isa_pkg::OP_SUB);
  assign sets_z   = is_arith || (opcode == cpu_isa_pkg::OP_XOR) ||
                    (opcode == cpu_isa_pkg::OP_SLL) || (opcode == cpu_isa_pkg::OP_SRA) ||
                    (opcode == cpu_isa_pkg::OP_ROR);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (!stall) begin
      if (sets_z) flags[cpu_isa_pkg::FLAG_Z_BIT] <= (alu_out == '0);
      // V flags a clamped result and N follows the sign of what was written
      if (is_arith) begin
        flags[cpu_isa_pkg::FLAG_V_BIT] <= arith_ovf;
        flags[cpu_isa_pkg::FLAG_N_BIT] <= alu_out[15];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mem_wb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Memory stage to MEM/WB register, plus the writeback value coming back for store forwarding
interface mem_wb_if;

  cpu_isa_pkg::word_t pc_next;
  cpu_isa_pkg::word_t alu_out;
  cpu_isa_pkg::word_t mem_rdata;   // Combinational read of the data memory
  pipe_pkg::wb_ctrl_t wb_ctrl;

  cpu_isa_pkg::word_t fwd_data;    // Value the WB stage is writing this cycle
  pipe_pkg::wb_ctrl_t fwd_wb_ctrl; // Registered writeback bundle of that entry

  modport source (output pc_next, alu_out, mem_rdata, wb_ctrl); // Memory stage drives
  modport sink (input pc_next, alu_out, mem_rdata, wb_ctrl);    // MEM/WB register samples

  // Return path for forwarding
  modport fwd_src (output fwd_data, fwd_wb_ctrl);
  modport fwd (input fwd_data, fwd_wb_ctrl);

endinterface

`default_nettype wire

// ==== verilog/ex_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Everything the EX/MEM register hands to the memory stage
interface ex_mem_if;

  cpu_isa_pkg::word_t     pc_next;  // Return address for PCS
  cpu_isa_pkg::word_t     alu_out;  // Result or memory address
  cpu_isa_pkg::reg_addr_t src_reg2; // Store data source, compared for forwarding
  pipe_pkg::mem_ctrl_t    mem_ctrl;
  pipe_pkg::wb_ctrl_t     wb_ctrl;

  // Pipeline register side
  modport source (
    output pc_next, alu_out, src_reg2, mem_ctrl, wb_ctrl
  );

  // Memory stage side
  modport sink (
    input pc_next, alu_out, src_reg2, mem_ctrl, wb_ctrl
  );

endinterface

`default_nettype wire

// ==== verilog/pipe_pkg.sv ====
`default_nettype none

// Layout of the control bundles that travel down the pipe with each entry
package pipe_pkg;

  ////////////////////
  // Bundle types
  ////////////////////
  // Memory bundle is {write data, mem enable, mem write}
  typedef logic [17:0] mem_ctrl_t;
  // Writeback bundle is {rd, RegWrite, MemtoReg, HLT, PCS}
  typedef logic [7:0]  wb_ctrl_t;

  ////////////////////
  // Field positions
  ////////////////////
  localparam int MEM_WDATA_LSB = 2;  // Store data occupies bits 17 down to 2
  localparam int MEM_EN_BIT    = 1;
  localparam int MEM_WR_BIT    = 0;

  localparam int WB_RD_LSB       = 4; // Destination register in bits 7 down to 4
  localparam int WB_REGWRITE_BIT = 3;
  localparam int WB_MEMTOREG_BIT = 2; // Selects load data over the ALU result
  localparam int WB_HLT_BIT      = 1;
  localparam int WB_PCS_BIT      = 0; // Selects pc_next as writeback value

endpackage

`default_nettype wire

// ==== verilog/cpu_isa_pkg.sv ====
`default_nettype none

// Instruction set view of the back end: data widths, register numbers and opcodes
package cpu_isa_pkg;

  ////////////////////
  // Basic types
  ////////////////////
  typedef logic [15:0] word_t;     // Data word, ALU result or PC value
  typedef logic [3:0]  reg_addr_t; // Register file index, r0 to r15
  typedef logic [3:0]  opcode_t;   // Top nibble of the instruction
  typedef logic [2:0]  flags_t;    // Ordered Z, V, N from the MSB down

  // Bit positions inside flags_t
  localparam int FLAG_Z_BIT = 2;
  localparam int FLAG_V_BIT = 1;
  localparam int FLAG_N_BIT = 0;

  ////////////////////
  // Opcodes
  ////////////////////
  localparam opcode_t OP_ADD = 4'd0;  // Saturating add
  localparam opcode_t OP_SUB = 4'd1;  // Saturating subtract
  localparam opcode_t OP_XOR = 4'd2;
  localparam opcode_t OP_SLL = 4'd4;  // Shift amount from operand_b[3:0]
  localparam opcode_t OP_SRA = 4'd5;
  localparam opcode_t OP_ROR = 4'd6;
  localparam opcode_t OP_LW  = 4'd8;  // Address is base plus offset
  localparam opcode_t OP_SW  = 4'd9;
  localparam opcode_t OP_LLB = 4'd10; // Load low byte
  localparam opcode_t OP_LHB = 4'd11; // Load high byte

endpackage

`default_nettype wire
